// ==== flist.f ====
+incdir+design
+incdir+tb
design/csc_pkg.sv
design/video_pkg.sv
design/csc_mul.sv
design/csc_channel.sv
design/csc_rgb2ycbcr.sv
tb/tb_csc_top.sv

// ==== Makefile ====
# Verilator build and run of the rgb to ycbcr converter testbench

VERILATOR ?= verilator
TOP       ?= tb_csc_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build, run, then scan the log for the result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_csc_tests.svh ====
// reference model, expected-value queue and directed tests, included inside the testbench top

// expected outputs of one input cycle
typedef struct packed {
  sync_t  sync;
  tag_t   tag;
  field_t field;
  pixel_t y;
  pixel_t cb;
  pixel_t cr;
} expect_t;

// one entry per cycle in flight
expect_t exp_q [$];

// sign-magnitude to signed integer
function automatic int coef_val(input coef_t c);
  return c.sign ? -int'(c.mag) : int'(c.mag);
endfunction

function automatic coef_t make_coef(input int v);
  coef_t c;
  c.sign = (v < 0);
  c.mag  = (`CSC_COEF_W-1)'(v < 0 ? -v : v);
  return c;
endfunction

// weighted sum plus offset and half lsb, floor division by 256, clamp to 0..255
function automatic pixel_t ref_component(input pixel_t r, input pixel_t g, input pixel_t b,
                                         input coef_t c0, input coef_t c1, input coef_t c2,
                                         input pixel_t off);
  int acc;
  int q;
  acc = coef_val(c0) * int'(r) + coef_val(c1) * int'(g) + coef_val(c2) * int'(b)
      + int'(off) * 256 + 128;
  q = acc / 256;
  // integer division truncates, step down for negative remainders
  if (acc < 0 && q * 256 != acc) begin
    q = q - 1;
  end
  if (q < 0) begin
    return '0;
  end else if (q > 255) begin
    return '1;
  end
  return pixel_t'(q);
endfunction

function automatic pixel_t rand_pixel();
  logic [31:0] v;
  v = lcg_next();
  return v[31:24];
endfunction

task automatic set_config(input int y0, input int y1, input int y2,
                          input int cb0, input int cb1, input int cb2,
                          input int cr0, input int cr1, input int cr2,
                          input int oy, input int ocb, input int ocr);
  cy0    = make_coef(y0);
  cy1    = make_coef(y1);
  cy2    = make_coef(y2);
  ccb0   = make_coef(cb0);
  ccb1   = make_coef(cb1);
  ccb2   = make_coef(cb2);
  ccr0   = make_coef(cr0);
  ccr1   = make_coef(cr1);
  ccr2   = make_coef(cr2);
  off_y  = pixel_t'(oy);
  off_cb = pixel_t'(ocb);
  off_cr = pixel_t'(ocr);
endtask

// **************************************************
// drive and check
// **************************************************

// side-band every cycle, data only for valid pixels
task automatic check_outputs(input expect_t e);
  checks++;
  assert (out_sync == e.sync) else begin
    errors++;
    $display("Fail %0t: out_sync %b, expected %b", $time, out_sync, e.sync);
  end
  assert (out_tag == e.tag && out_field == e.field) else begin
    errors++;
    $display("Fail %0t: tag/field %h/%b, expected %h/%b", $time, out_tag, out_field,
             e.tag, e.field);
  end
  if (e.sync.valid) begin
    assert (out_y == e.y && out_cb == e.cb && out_cr == e.cr) else begin
      errors++;
      $display("Fail %0t: ycbcr %0d %0d %0d, expected %0d %0d %0d", $time,
               out_y, out_cb, out_cr, e.y, e.cb, e.cr);
    end
  end
endtask

// on each falling edge the oldest entry has just reached the outputs
task automatic step(input sync_t s, input tag_t t, input field_t f,
                    input pixel_t r, input pixel_t g, input pixel_t b);
  expect_t e;
  @(negedge clk);
  if (exp_q.size() == `CSC_LATENCY) begin
    check_outputs(exp_q.pop_front());
  end
  in_sync  = s;
  in_tag   = t;
  in_field = f;
  in_r     = r;
  in_g     = g;
  in_b     = b;
  e.sync   = s;
  e.tag    = t;
  e.field  = f;
  e.y      = ref_component(r, g, b, cy0, cy1, cy2, off_y);
  e.cb     = ref_component(r, g, b, ccb0, ccb1, ccb2, off_cb);
  e.cr     = ref_component(r, g, b, ccr0, ccr1, ccr2, off_cr);
  exp_q.push_back(e);
endtask

// idle cycles until every pixel has left the pipe
task automatic drain();
  repeat (`CSC_LATENCY) step('0, '0, 1'b0, '0, '0, '0);
endtask

// **************************************************
// directed tests
// **************************************************

task automatic test_reset_state();
  for (int i = 0; i < `CSC_LATENCY + 2; i++) begin
    step('0, '0, 1'b0, '0, '0, '0);
    checks++;
    assert (out_sync == '0) else begin
      errors++;
      $display("Fail %0t: out_sync %b after reset, expected 0", $time, out_sync);
    end
  end
endtask

// Y=R, Cb=G, Cr=B, first two pixels black and white
task automatic test_identity();
  sync_t  s;
  pixel_t r;
  pixel_t g;
  pixel_t b;
  set_config(256, 0, 0, 0, 256, 0, 0, 0, 256, 0, 0, 0);
  for (int i = 0; i < N_IDENT; i++) begin
    r = (i == 1) ? 8'hff : rand_pixel();
    g = (i == 1) ? 8'hff : rand_pixel();
    b = (i == 1) ? 8'hff : rand_pixel();
    if (i == 0) begin
      r = '0;
      g = '0;
      b = '0;
    end
    s.valid = 1'b1;
    s.de    = 1'b1;
    s.hsync = (i % 5 == 0);
    s.vsync = (i < 2);
    step(s, tag_t'(i * 13), field_t'(i % 2), r, g, b);
  end
  drain();
endtask

// studio-range coefficients scaled by 256, back to back
task automatic test_bt601();
  sync_t s;
  set_config(66, 129, 25, -38, -74, 112, 112, -94, -18, 16, 128, 128);
  for (int i = 0; i < N_RANDOM; i++) begin
    s = '{valid: 1'b1, de: 1'b1, hsync: (i % 40 == 0), vsync: 1'b0};
    step(s, tag_t'(i), field_t'(i / 100), rand_pixel(), rand_pixel(), rand_pixel());
  end
  drain();
endtask

// white drives Y and Cr past full scale and Cb far below zero
task automatic test_saturation();
  sync_t s;
  set_config(512, 512, 512, -65535, -65535, -65535, 65535, 65535, 65535, 16, 0, 255);
  s = '{valid: 1'b1, de: 1'b1, hsync: 1'b0, vsync: 1'b0};
  for (int i = 0; i < N_SAT; i++) begin
    step(s, tag_t'(8'hf0 + i), 1'b1, 8'hff, 8'hff, 8'hff);
  end
  drain();
endtask

// random gaps, sync lines keep toggling while valid is low
task automatic test_gapped();
  sync_t       s;
  logic [31:0] rnd;
  set_config(66, 129, 25, -38, -74, 112, 112, -94, -18, 16, 128, 128);
  for (int i = 0; i < N_GAP; i++) begin
    rnd     = lcg_next();
    s.valid = rnd[31];
    s.de    = rnd[31] | rnd[30];
    s.hsync = (i % 7 == 0);
    s.vsync = (i % 23 < 2);
    step(s, rnd[23:16], field_t'((i / 8) % 2), rand_pixel(), rand_pixel(), rand_pixel());
  end
  drain();
endtask

// ==== tb/tb_csc_top.sv ====
// testbench top for the rgb to ycbcr converter that runs the directed tests and reports the result
`timescale 1ns/100ps
`include "csc_settings.svh"

module tb_csc_top import csc_pkg::*, video_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;

  // pixels per test
  localparam int N_IDENT  = 16;
  localparam int N_RANDOM = 200;
  localparam int N_SAT    = 4;
  localparam int N_GAP    = 60;

  // every test ends with a drain of one latency
  localparam int TOTAL_CYCLES = RESET_CYCLES + (`CSC_LATENCY + 2)
                              + N_IDENT + N_RANDOM + N_SAT + N_GAP + 4 * `CSC_LATENCY;
  localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 50) * CLK_PERIOD;

  logic   clk;
  logic   reset;
  sync_t  in_sync;
  tag_t   in_tag;
  field_t in_field;
  pixel_t in_r;
  pixel_t in_g;
  pixel_t in_b;
  coef_t  cy0;
  coef_t  cy1;
  coef_t  cy2;
  coef_t  ccb0;
  coef_t  ccb1;
  coef_t  ccb2;
  coef_t  ccr0;
  coef_t  ccr1;
  coef_t  ccr2;
  pixel_t off_y;
  pixel_t off_cb;
  pixel_t off_cr;
  sync_t  out_sync;
  tag_t   out_tag;
  field_t out_field;
  pixel_t out_y;
  pixel_t out_cb;
  pixel_t out_cr;

  int          checks;
  int          errors;
  logic [31:0] lcg_state;

  // **************************************************
  // clock, DUT
  // **************************************************

  always #(CLK_PERIOD / 2) clk = ~clk;

  csc_rgb2ycbcr DUT (
    .clk (clk), .reset (reset),
    .in_sync (in_sync), .in_tag (in_tag), .in_field (in_field),
    .in_r (in_r), .in_g (in_g), .in_b (in_b),
    .cy0 (cy0), .cy1 (cy1), .cy2 (cy2),
    .ccb0 (ccb0), .ccb1 (ccb1), .ccb2 (ccb2),
    .ccr0 (ccr0), .ccr1 (ccr1), .ccr2 (ccr2),
    .off_y (off_y), .off_cb (off_cb), .off_cr (off_cr),
    .out_sync (out_sync), .out_tag (out_tag), .out_field (out_field),
    .out_y (out_y), .out_cb (out_cb), .out_cr (out_cr)
  );

  // 32-bit LCG with the numerical recipes constants
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  `include "tb_csc_tests.svh"

  // **************************************************
  // test sequence
  // **************************************************

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    checks   = 0;
    errors   = 0;
    lcg_state = 32'd88;
    // valid and sync stay high through reset and must not reach the outputs
    in_sync  = '1;
    in_tag   = '0;
    in_field = 1'b0;
    in_r     = '0;
    in_g     = '0;
    in_b     = '0;
    set_config(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    repeat (RESET_CYCLES) @(negedge clk);
    reset   = 1'b0;
    in_sync = '0;

    test_reset_state();
    test_identity();
    test_bt601();
    test_saturation();
    test_gapped();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // ends a run that stalls past the expected length
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("checks %0d, errors %0d", checks, errors);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== design/csc_rgb2ycbcr.sv ====
// rgb to ycbcr converter top, three channels with sync, tag and field carried alongside
`timescale 1ns/100ps

module csc_rgb2ycbcr import csc_pkg::*, video_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  sync_t  in_sync,
  input  tag_t   in_tag,
  input  field_t in_field,
  input  pixel_t in_r,
  input  pixel_t in_g,
  input  pixel_t in_b,
  input  coef_t  cy0,
  input  coef_t  cy1,
  input  coef_t  cy2,
  input  coef_t  ccb0,
  input  coef_t  ccb1,
  input  coef_t  ccb2,
  input  coef_t  ccr0,
  input  coef_t  ccr1,
  input  coef_t  ccr2,
  input  pixel_t off_y,
  input  pixel_t off_cb,
  input  pixel_t off_cr,
  output sync_t  out_sync,
  output tag_t   out_tag,
  output field_t out_field,
  output pixel_t out_y,
  output pixel_t out_cb,
  output pixel_t out_cr
);

  sync_t  sb_sync;
  tag_t   sb_tag;
  field_t sb_field;

  // **************************************************
  // reset stage
  // **************************************************

  // channel pipes have no reset, so zeros are fed in while reset is held
  // a reset longer than the latency flushes valid out of every stage
  always_comb begin
    sb_sync  = reset ? '0 : in_sync;
    sb_tag   = reset ? '0 : in_tag;
    sb_field = reset ? '0 : in_field;
  end

  // **************************************************
  // conversion channels
  // **************************************************

  // Y carries the sync bundle
  csc_channel #(.ddata_t(sync_t)) i_chan_y (
    .clk (clk), .r (in_r), .g (in_g), .b (in_b),
    .c0 (cy0), .c1 (cy1), .c2 (cy2), .offset (off_y),
    .ddata (sb_sync), .ddata_out (out_sync), .out (out_y)
  );

  // Cb carries the user tag
  csc_channel #(.ddata_t(tag_t)) i_chan_cb (
    .clk (clk), .r (in_r), .g (in_g), .b (in_b),
    .c0 (ccb0), .c1 (ccb1), .c2 (ccb2), .offset (off_cb),
    .ddata (sb_tag), .ddata_out (out_tag), .out (out_cb)
  );

  // Cr carries the field id
  csc_channel #(.ddata_t(field_t)) i_chan_cr (
    .clk (clk), .r (in_r), .g (in_g), .b (in_b),
    .c0 (ccr0), .c1 (ccr1), .c2 (ccr2), .offset (off_cr),
    .ddata (sb_field), .ddata_out (out_field), .out (out_cr)
  );

endmodule

// ==== design/csc_channel.sv ====
// one converted component, weighted sum of r, g, b plus offset, rounded and clamped to 0..255
`timescale 1ns/100ps
`include "csc_settings.svh"

module csc_channel import csc_pkg::*; #(
  parameter type ddata_t = logic
) (
  input  logic   clk,
  input  pixel_t r,
  input  pixel_t g,
  input  pixel_t b,
  input  coef_t  c0,
  input  coef_t  c1,
  input  coef_t  c2,
  input  pixel_t offset,
  input  ddata_t ddata,
  output ddata_t ddata_out,
  output pixel_t out
);

  // registers added after the multipliers
  localparam int XDLY    = `CSC_LATENCY - `CSC_MUL_LATENCY;
  localparam int SUM_MSB = $bits(sum_t) - 1;

  product_t prod_r;
  product_t prod_g;
  product_t prod_b;
  ddata_t   mul_ddata;

  // cycle 4 accumulation
  sum_t     s4_sum;

  // cycle 5 combinational round and shift
  sum_t     acc;
  sum_t     shifted;

  ddata_t   d_dly [XDLY];

  // sign-magnitude to two's complement
  function automatic sum_t to_sum(input product_t p);
    sum_t m;
    m = sum_t'(p.mag);
    return p.sign ? -m : m;
  endfunction

  // **************************************************
  // multipliers, cycles 1 to 3
  // **************************************************

  // only the first multiplier carries the payload
  csc_mul #(.ddata_t(ddata_t)) i_mul_r (
    .clk       (clk),
    .coef      (c0),
    .pix       (r),
    .prod      (prod_r),
    .ddata     (ddata),
    .ddata_out (mul_ddata)
  );

  csc_mul #(.ddata_t(logic)) i_mul_g (
    .clk       (clk),
    .coef      (c1),
    .pix       (g),
    .prod      (prod_g),
    .ddata     (1'b0),
    .ddata_out ()
  );

  csc_mul #(.ddata_t(logic)) i_mul_b (
    .clk       (clk),
    .coef      (c2),
    .pix       (b),
    .prod      (prod_b),
    .ddata     (1'b0),
    .ddata_out ()
  );

  // **************************************************
  // sum, round and clamp, cycles 4 and 5
  // **************************************************

  always_ff @(posedge clk) begin
    s4_sum <= to_sum(prod_r) + to_sum(prod_g) + to_sum(prod_b);
  end

  // offset moves into Q8.8, then half an lsb before the shift
  always_comb begin
    acc = s4_sum + (sum_t'(offset) <<< `CSC_FRAC_BITS)
        + (sum_t'(1) <<< (`CSC_FRAC_BITS - 1));
    shifted = acc >>> `CSC_FRAC_BITS;
  end

  // negative goes to 0, anything above 8 bits goes to full scale
  always_ff @(posedge clk) begin
    if (shifted[SUM_MSB]) begin
      out <= '0;
    end else if (|shifted[SUM_MSB-1:`CSC_PIX_W]) begin
      out <= '1;
    end else begin
      out <= shifted[`CSC_PIX_W-1:0];
    end
  end

  // payload catches up with the two adder stages
  always_ff @(posedge clk) begin
    d_dly[0] <= mul_ddata;
    for (int i = 1; i < XDLY; i++) begin
      d_dly[i] <= d_dly[i-1];
    end
  end

  assign ddata_out = d_dly[XDLY-1];

endmodule

// ==== design/csc_mul.sv ====
// three-stage sign-magnitude coefficient by pixel multiplier with a delay-matched payload path
`timescale 1ns/100ps
`include "csc_settings.svh"

module csc_mul import csc_pkg::*; #(
  parameter type ddata_t = logic
) (
  input  logic     clk,
  input  coef_t    coef,
  input  pixel_t   pix,
  output product_t prod,
  input  ddata_t   ddata,
  output ddata_t   ddata_out
);

  // stage 1 operands
  pixel_t                  p1_pix;
  logic [`CSC_COEF_W-2:0]  p1_mag;
  logic                    p1_sign;

  // stage 2 raw magnitude product
  logic [$bits(prod.mag)-1:0] p2_mag;
  logic                       p2_sign;

  // payload shift register, one entry per multiplier stage
  ddata_t d_pipe [`CSC_MUL_LATENCY];

  // **************************************************
  // datapath stages
  // **************************************************

  // stage 1, split coefficient into sign and magnitude
  always_ff @(posedge clk) begin
    p1_pix  <= pix;
    p1_mag  <= coef.mag;
    p1_sign <= coef.sign;
  end

  // stage 2, unsigned 16x8 multiply
  always_ff @(posedge clk) begin
    p2_mag  <= p1_mag * p1_pix;
    p2_sign <= p1_sign;
  end

  // stage 3, rebuild sign-magnitude
  // a zero magnitude never carries a minus sign
  always_ff @(posedge clk) begin
    prod.mag  <= p2_mag;
    prod.sign <= p2_sign & (|p2_mag);
  end

  // **************************************************
  // delay match
  // **************************************************

  // side data rides the same number of registers as the product
  always_ff @(posedge clk) begin
    d_pipe[0] <= ddata;
    for (int i = 1; i < `CSC_MUL_LATENCY; i++) begin
      d_pipe[i] <= d_pipe[i-1];
    end
  end

  assign ddata_out = d_pipe[`CSC_MUL_LATENCY-1];

endmodule

// ==== design/video_pkg.sv ====
// video side-band types that travel beside the pixels, imported by the top level and testbench

package video_pkg;

  // sync bundle, valid is the single-cycle pixel strobe
  // no back-pressure anywhere in the pipe
  typedef struct packed {
    logic valid;
    logic de;
    logic hsync;
    logic vsync;
  } sync_t;

  // free user tag per pixel
  typedef logic [7:0] tag_t;

  // interlace field id
  // 0 is the first field
  typedef logic field_t;

endpackage

// ==== design/csc_pkg.sv ====
// arithmetic types of the color converter datapath, imported by the multiplier, channel and top
`include "csc_settings.svh"

package csc_pkg;

  // one unsigned color component
  typedef logic [`CSC_PIX_W-1:0] pixel_t;

  // sign-magnitude coefficient, magnitude scaled by 2^frac
  typedef struct packed {
    logic                    sign;
    logic [`CSC_COEF_W-2:0]  mag;
  } coef_t;

  // sign-magnitude product, 16-bit magnitude times 8-bit pixel
  typedef struct packed {
    logic                                sign;
    logic [`CSC_COEF_W+`CSC_PIX_W-2:0]   mag;
  } product_t;

  // two's complement accumulator
  // two guard bits above the product magnitude hold three terms plus offset
  typedef logic signed [`CSC_COEF_W+`CSC_PIX_W+1:0] sum_t;

endpackage

// ==== design/csc_settings.svh ====
// widths, fraction bits and pipeline latencies shared by the color converter, include where needed
`ifndef CSC_SETTINGS_SVH
`define CSC_SETTINGS_SVH

// pixel component width, one 8-bit color sample
`define CSC_PIX_W 8

// coefficient is sign bit plus 16-bit magnitude
`define CSC_COEF_W 17

// fraction bits in the coefficient magnitude, Q8.8
`define CSC_FRAC_BITS 8

// pipeline depth of the coefficient multiplier
`define CSC_MUL_LATENCY 3
// pixel in to component out, multiplier plus sum and round stages
`define CSC_LATENCY 5

`endif
